// File: dv/tb_axil_tasks.svh
// axi4-lite master tasks, one transfer at a time, included inside tb_rp_top
// called on a falling clock edge, handshake waits give up after WAIT_LIMIT cycles

localparam int WAIT_LIMIT = 50;            // cycles per handshake wait

// put aw and w on the bus together, full strobe
task automatic drive_write(input logic [31:0] addr, input logic [31:0] data);
  s_awaddr_i  = addr;
  s_wdata_i   = data;
  s_wstrb_i   = 4'hF;
  s_awvalid_i = 1'b1;
  s_wvalid_i  = 1'b1;
endtask

task automatic wait_write_accept();
  int cnt;
  cnt = 0;
  #1;                                      // ready decode settles after the drive
  while (!s_awready_o && cnt < WAIT_LIMIT)
  begin
    @(negedge adc_clk);
    #1;
    cnt++;
  end
  if (s_awready_o)
  begin
    @(negedge adc_clk);                    // handshake on the rising edge between
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
  end
  else
    report_fail("write address and data were never accepted");
endtask

// bvalid is registered, so the falling edge sees it stable
task automatic wait_bvalid();
  int cnt;
  cnt = 0;
  while (!s_bvalid_o && cnt < WAIT_LIMIT)
  begin
    @(negedge adc_clk);
    cnt++;
  end
  if (!s_bvalid_o)
    report_fail("write response never arrived");
endtask

task automatic wait_write_resp();
  wait_bvalid();
  @(negedge adc_clk);                      // b handshake, bready high here
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
  drive_write(addr, data);
  wait_write_accept();
  wait_write_resp();
endtask

// expected data only checked on okay
task automatic bus_read(input logic [31:0] addr, input logic [31:0] data,
                        input logic [1:0] resp);
  int cnt;
  exp_rdata   = data;
  exp_rresp   = resp;
  rdata_chk   = (resp == RESP_OKAY);
  s_araddr_i  = addr;
  s_arvalid_i = 1'b1;
  cnt = 0;
  #1;
  while (!s_arready_o && cnt < WAIT_LIMIT)
  begin
    @(negedge adc_clk);
    #1;
    cnt++;
  end
  if (!s_arready_o)
    report_fail("read address was never accepted");
  else
  begin
    @(negedge adc_clk);
    s_arvalid_i = 1'b0;
    cnt = 0;
    while (!s_rvalid_o && cnt < WAIT_LIMIT)
    begin
      @(negedge adc_clk);
      cnt++;
    end
    if (s_rvalid_o)
      @(negedge adc_clk);                  // r handshake, checked by assertion
    else
      report_fail("read data never arrived");
  end
endtask

// File: dv/tb_rp_top.sv
// testbench for rp_top, drives the axi4-lite port and the adc pins
// concurrent assertions compare the dac words with a delayed model of the inputs

`timescale 1ns/1ns

module tb_rp_top;

  localparam int MODE_OFF      = 0;        // data checks idle
  localparam int MODE_PASS     = 1;
  localparam int MODE_CROSS    = 2;
  localparam int MODE_NEG_ZERO = 3;        // a negated, b zeroed
  localparam int MODE_LOOP     = 4;

  localparam logic [31:0] ADDR_HK_ID    = 32'h0000_0000;
  localparam logic [31:0] ADDR_HK_LOOP  = 32'h0000_0004;
  localparam logic [31:0] ADDR_HK_LED   = 32'h0000_0008;
  localparam logic [31:0] ADDR_HK_HOLE  = 32'h0000_000C;  // unmapped in region 0
  localparam logic [31:0] ADDR_ROUTE_A  = 32'h0030_0000;  // region 3
  localparam logic [31:0] ADDR_ROUTE_B  = 32'h0030_0004;
  localparam logic [31:0] ADDR_REGION_5 = 32'h0050_0000;
  localparam logic [1:0]  RESP_OKAY     = 2'b00;
  localparam logic [1:0]  RESP_SLVERR   = 2'b10;
  localparam logic [13:0] DAC_ZERO      = 14'h1FFF;

  logic        adc_clk;
  logic        arst_n_i;
  logic [31:0] s_awaddr_i;
  logic        s_awvalid_i;
  logic        s_awready_o;
  logic [31:0] s_wdata_i;
  logic [3:0]  s_wstrb_i;
  logic        s_wvalid_i;
  logic        s_wready_o;
  logic [1:0]  s_bresp_o;
  logic        s_bvalid_o;
  logic        s_bready_i;
  logic [31:0] s_araddr_i;
  logic        s_arvalid_i;
  logic        s_arready_o;
  logic [31:0] s_rdata_o;
  logic [1:0]  s_rresp_o;
  logic        s_rvalid_o;
  logic        s_rready_i;
  logic [15:0] adc_dat_a_i;
  logic [15:0] adc_dat_b_i;
  logic [13:0] dac_dat_a_o;
  logic [13:0] dac_dat_b_o;
  logic        dac_rst_o;
  logic [7:0]  led_o;

  int          seed;
  string       test_name;
  int          chk_mode;
  logic        data_chk;
  logic        loop_chk;
  logic        led_chk;
  logic        rdata_chk;
  logic [7:0]  exp_led;
  logic [31:0] exp_rdata;
  logic [1:0]  exp_rresp;
  logic [15:0] adc_a_dly [3];              // input delay line, one per stage
  logic [15:0] adc_b_dly [3];
  logic [13:0] dac_a_prev;
  logic [13:0] dac_b_prev;
  logic [13:0] exp_dac_a;
  logic [13:0] exp_dac_b;

  rp_top dut_i (.*);                       // port names match the tb signals

  always #5 adc_clk = ~adc_clk;            // 10 ns period

  task automatic report_fail(input string line);
    $display(">>> FAIL");
    $display("%s", line);
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    report_fail($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  `include "tb_axil_tasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // negative slope offset code, code 0 is full scale positive
  function automatic int adc_code_to_int(input logic [13:0] code);
    int low;
    int val;
    low = int'(code[12:0]);
    if (code[13])
      val = -1 - low;
    else
      val = 8191 - low;
    return val;
  endfunction

  function automatic logic [13:0] int_to_dac_code(input int val);
    logic [13:0] code;
    if (val >= 0)
      code = {1'b0, 13'(8191 - val)};
    else
      code = {1'b1, 13'(-1 - val)};
    return code;
  endfunction

  function automatic int negate_saturated(input int val);
    int res;
    res = -val;
    if (res > 8191)
      res = 8191;                          // -(-8192) clips
    return res;
  endfunction

  always @(posedge adc_clk)
  begin
    adc_a_dly[0] <= adc_dat_a_i;
    adc_a_dly[1] <= adc_a_dly[0];
    adc_a_dly[2] <= adc_a_dly[1];
    adc_b_dly[0] <= adc_dat_b_i;
    adc_b_dly[1] <= adc_b_dly[0];
    adc_b_dly[2] <= adc_b_dly[1];
    dac_a_prev   <= dac_dat_a_o;
    dac_b_prev   <= dac_dat_b_o;
  end

  always_comb
  begin
    exp_dac_a = DAC_ZERO;
    exp_dac_b = DAC_ZERO;
    case (chk_mode)
      MODE_PASS:
      begin
        exp_dac_a = adc_a_dly[2][15:2];    // both conversions cancel
        exp_dac_b = adc_b_dly[2][15:2];
      end
      MODE_CROSS:
      begin
        exp_dac_a = adc_b_dly[2][15:2];
        exp_dac_b = adc_a_dly[2][15:2];
      end
      MODE_NEG_ZERO:
        exp_dac_a = int_to_dac_code(negate_saturated(adc_code_to_int(adc_a_dly[2][15:2])));
      default:
        exp_dac_a = DAC_ZERO;
    endcase
  end

  assign data_chk = (chk_mode != MODE_OFF) && (chk_mode != MODE_LOOP);
  assign loop_chk = (chk_mode == MODE_LOOP);

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_dac: assert property (@(posedge adc_clk)
    !arst_n_i |-> dac_rst_o && dac_dat_a_o == DAC_ZERO && dac_dat_b_o == DAC_ZERO)
    else report_mismatch("reset_values", {3'd0, 1'b1, DAC_ZERO, DAC_ZERO},
                         32'({$sampled(dac_rst_o), $sampled(dac_dat_a_o),
                              $sampled(dac_dat_b_o)}));
  a_rst_release: assert property (@(posedge adc_clk)
    $rose(arst_n_i) |-> dac_rst_o)         // one cycle beyond reset
    else report_mismatch("reset_release", 32'd1, 32'($sampled(dac_rst_o)));
  a_rst_low: assert property (@(posedge adc_clk)
    arst_n_i && $past(arst_n_i) |-> !dac_rst_o)
    else report_mismatch("reset_release", 32'd0, 32'($sampled(dac_rst_o)));

  a_dac_a: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    data_chk |-> dac_dat_a_o == exp_dac_a)
    else report_mismatch(test_name, 32'($sampled(exp_dac_a)), 32'($sampled(dac_dat_a_o)));
  a_dac_b: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    data_chk |-> dac_dat_b_o == exp_dac_b)
    else report_mismatch(test_name, 32'($sampled(exp_dac_b)), 32'($sampled(dac_dat_b_o)));
  a_loop_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    loop_chk |-> dac_dat_a_o == dac_a_prev && dac_dat_b_o == dac_b_prev)
    else report_mismatch(test_name, 32'({$sampled(dac_a_prev), $sampled(dac_b_prev)}),
                         32'({$sampled(dac_dat_a_o), $sampled(dac_dat_b_o)}));

  a_bresp: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_bvalid_o && s_bready_i |-> s_bresp_o == RESP_OKAY)  // only mapped writes
    else report_mismatch(test_name, 32'(RESP_OKAY), 32'($sampled(s_bresp_o)));
  a_rresp: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_rvalid_o && s_rready_i |-> s_rresp_o == exp_rresp)
    else report_mismatch(test_name, 32'($sampled(exp_rresp)), 32'($sampled(s_rresp_o)));
  a_rdata: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_rvalid_o && s_rready_i && rdata_chk |-> s_rdata_o == exp_rdata)
    else report_mismatch(test_name, $sampled(exp_rdata), $sampled(s_rdata_o));
  a_led: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    led_chk |-> led_o == exp_led)
    else report_mismatch(test_name, 32'($sampled(exp_led)), 32'($sampled(led_o)));

  // back-pressure, no new write while b is stalled
  a_bp_block: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_bvalid_o && !s_bready_i |-> !s_awready_o && !s_wready_o)
    else report_mismatch("back_pressure", 32'd0, 32'($sampled(s_awready_o)));
  a_bp_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o)
    else report_mismatch("back_pressure", 32'd1, 32'($sampled(s_bvalid_o)));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_random(input int n);
    repeat (n)
    begin
      adc_dat_a_i = 16'($random(seed));
      adc_dat_b_i = 16'($random(seed));
      @(negedge adc_clk);
    end
  endtask

  task automatic drive_pair(input logic [15:0] a, input logic [15:0] b);
    adc_dat_a_i = a;
    adc_dat_b_i = b;
    @(negedge adc_clk);
  endtask

  // let config and pipeline settle before arming the data checks
  task automatic arm_checks(input int mode);
    repeat (4) @(negedge adc_clk);
    chk_mode = mode;
  endtask

  initial
  begin
    seed        = 28096;
    test_name   = "reset_values";
    chk_mode    = MODE_OFF;
    led_chk     = 1'b1;                    // leds stay 0 until written
    rdata_chk   = 1'b0;
    exp_led     = 8'h00;
    exp_rdata   = 32'd0;
    exp_rresp   = RESP_OKAY;
    adc_clk     = 1'b0;
    arst_n_i    = 1'b1;
    s_awaddr_i  = 32'd0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = 32'd0;
    s_wstrb_i   = 4'h0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b1;
    s_araddr_i  = 32'd0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b1;
    adc_dat_a_i = 16'h7FFC;                // zero code on the pins
    adc_dat_b_i = 16'h7FFC;
    #1 arst_n_i = 1'b0;                    // real falling edge for the async reset
    repeat (3) @(negedge adc_clk);
    arst_n_i = 1'b1;
    repeat (2) @(negedge adc_clk);

    test_name = "pass_through";            // default routes
    arm_checks(MODE_PASS);
    drive_random(60);

    test_name = "route_cross";
    chk_mode  = MODE_OFF;
    bus_write(ADDR_ROUTE_A, 32'd1);
    bus_write(ADDR_ROUTE_B, 32'd1);
    bus_read(ADDR_ROUTE_B, 32'd1, RESP_OKAY);
    arm_checks(MODE_CROSS);
    drive_random(40);

    test_name = "route_neg_zero";
    chk_mode  = MODE_OFF;
    bus_write(ADDR_ROUTE_A, 32'd2);
    bus_write(ADDR_ROUTE_B, 32'd3);
    arm_checks(MODE_NEG_ZERO);
    drive_pair(16'hFFFC, 16'h0000);        // most negative on a
    drive_pair(16'h0000, 16'hFFFC);        // most positive on a
    drive_pair(16'hFFFF, 16'h1234);
    drive_random(40);

    test_name = "digital_loop";
    chk_mode  = MODE_OFF;
    bus_write(ADDR_ROUTE_A, 32'd0);
    bus_write(ADDR_ROUTE_B, 32'd0);
    bus_write(ADDR_HK_LOOP, 32'd1);
    bus_read(ADDR_HK_LOOP, 32'd1, RESP_OKAY);
    arm_checks(MODE_LOOP);
    drive_random(40);
    chk_mode = MODE_OFF;
    bus_write(ADDR_HK_LOOP, 32'd0);

    test_name = "register_map";
    bus_read(ADDR_HK_ID, 32'h5250_0014, RESP_OKAY);
    led_chk = 1'b0;
    bus_write(ADDR_HK_LED, 32'h0000_005A);
    exp_led = 8'h5A;
    led_chk = 1'b1;
    bus_read(ADDR_HK_LED, 32'h0000_005A, RESP_OKAY);
    bus_read(ADDR_REGION_5, 32'd0, RESP_OKAY);
    bus_read(ADDR_HK_HOLE, 32'd0, RESP_SLVERR);

    test_name  = "back_pressure";
    led_chk    = 1'b0;
    s_bready_i = 1'b0;
    drive_write(ADDR_HK_LED, 32'h0000_00A5);
    wait_write_accept();
    wait_bvalid();
    exp_led = 8'hA5;
    led_chk = 1'b1;                        // second write must not land yet
    drive_write(ADDR_HK_LED, 32'h0000_003C);
    repeat (6) @(negedge adc_clk);
    led_chk    = 1'b0;
    s_bready_i = 1'b1;
    wait_write_accept();
    wait_write_resp();
    exp_led = 8'h3C;
    led_chk = 1'b1;
    repeat (3) @(negedge adc_clk);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+dv
logic/rp_pkg.sv
logic/axil_bus_slave.sv
logic/ctrl_regs.sv
logic/adc_frontend.sv
logic/signal_router.sv
logic/dac_frontend.sv
logic/rp_top.sv
dv/tb_rp_top.sv

// File: logic/adc_frontend.sv
// stage 1 of the sample path, registers the adc pins and converts to signed
// loop mode swaps in the router outputs after the conversion

`timescale 1ns/1ns

module adc_frontend #(
  parameter int DAT_W = rp_pkg::SAMPLE_W
) (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_raw_a_i,     // ch a pins
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_raw_b_i,     // ch b pins
  input  logic                         digital_loop_i,
  input  logic signed [DAT_W-1:0]      loop_a_i,        // from router
  input  logic signed [DAT_W-1:0]      loop_b_i,
  output logic signed [DAT_W-1:0]      smp_a_o,
  output logic signed [DAT_W-1:0]      smp_b_o
);

  import rp_pkg::*;

  // raw code of a zero sample
  localparam logic [DAT_W-1:0] RAW_ZERO = {1'b0, {(DAT_W-1){1'b1}}};

  logic [DAT_W-1:0]        adc_dat_a;
  logic [DAT_W-1:0]        adc_dat_b;
  logic signed [DAT_W-1:0] conv_a;
  logic signed [DAT_W-1:0] conv_b;

  // input register, reserved low bits dropped
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_dat_a <= RAW_ZERO;
      adc_dat_b <= RAW_ZERO;
    end
    else
    begin
      adc_dat_a <= adc_raw_a_i[ADC_RAW_W-1 -: DAT_W];
      adc_dat_b <= adc_raw_b_i[ADC_RAW_W-1 -: DAT_W];
    end
  end

  // negative-slope offset code to two's complement
  assign conv_a = {adc_dat_a[DAT_W-1], ~adc_dat_a[DAT_W-2:0]};
  assign conv_b = {adc_dat_b[DAT_W-1], ~adc_dat_b[DAT_W-2:0]};

  assign smp_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign smp_b_o = digital_loop_i ? loop_b_i : conv_b;

endmodule

// File: logic/axil_bus_slave.sv
// axi4-lite slave, one transfer at a time, writes win over reads
// hands single requests to the register block and holds the b/r response

`timescale 1ns/1ns

module axil_bus_slave (
  input  logic             adc_clk,
  input  logic             arst_n_i,
  // write address
  input  logic [31:0]      s_awaddr_i,
  input  logic             s_awvalid_i,
  output logic             s_awready_o,
  // write data
  input  logic [31:0]      s_wdata_i,
  input  logic [3:0]       s_wstrb_i,
  input  logic             s_wvalid_i,
  output logic             s_wready_o,
  // write response
  output logic [1:0]       s_bresp_o,
  output logic             s_bvalid_o,
  input  logic             s_bready_i,
  // read address
  input  logic [31:0]      s_araddr_i,
  input  logic             s_arvalid_i,
  output logic             s_arready_o,
  // read data
  output logic [31:0]      s_rdata_o,
  output logic [1:0]       s_rresp_o,
  output logic             s_rvalid_o,
  input  logic             s_rready_i,
  // register side
  output rp_pkg::reg_req_t req_o,
  input  rp_pkg::reg_rsp_t rsp_i
);

  import rp_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WR_RESP,                               // bvalid up, waiting for bready
    RD_RESP                                // rvalid up, waiting for rready
  } bus_state_e;

  bus_state_e  state_q;
  bus_state_e  state_d;
  logic        wr_accept;
  logic        rd_accept;
  logic [31:0] addr;                       // address of the accepted transfer
  logic [1:0]  bresp_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  // aw and w must arrive together, no pending b in idle
  assign wr_accept = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_accept = (state_q == IDLE) && s_arvalid_i && !wr_accept;

  assign s_awready_o = wr_accept;          // single-cycle pulse
  assign s_wready_o  = wr_accept;
  assign s_arready_o = rd_accept;

  assign addr = wr_accept ? s_awaddr_i : s_araddr_i;

  // request to ctrl_regs, answered in the same cycle
  always_comb
  begin
    req_o        = '0;
    req_o.wr     = wr_accept;
    req_o.rd     = rd_accept;
    req_o.region = addr[REGION_LSB +: REGION_W];  // addr[22:20]
    req_o.offset = addr[REGION_LSB-1:0];
    req_o.wdata  = s_wdata_i;
    req_o.wstrb  = wr_accept ? s_wstrb_i : 4'h0;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (wr_accept)
          state_d = WR_RESP;
        else if (rd_accept)
          state_d = RD_RESP;
      end
      WR_RESP: if (s_bready_i) state_d = IDLE;
      RD_RESP: if (s_rready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // response capture, only read while the matching valid is up
  always_ff @(posedge adc_clk)
  begin
    if (wr_accept)
      bresp_q <= rsp_i.err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    if (rd_accept)
    begin
      rresp_q <= rsp_i.err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
      rdata_q <= rsp_i.rdata;
    end
  end

  assign s_bvalid_o = (state_q == WR_RESP);
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = (state_q == RD_RESP);
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////////////////////

  a_bvalid_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o);

  a_rvalid_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

// File: logic/ctrl_regs.sv
// region decoder plus housekeeping (id, loop, leds) and dsp routing registers
// combinational response, unused regions read zero without error

`timescale 1ns/1ns

module ctrl_regs (
  input  logic             adc_clk,
  input  logic             arst_n_i,
  input  rp_pkg::reg_req_t req_i,
  output rp_pkg::reg_rsp_t rsp_o,
  output rp_pkg::dsp_cfg_t dsp_cfg_o,
  output logic             digital_loop_o,
  output logic [7:0]       led_o
);

  import rp_pkg::*;

  logic [NUM_REGIONS-1:0] region_cs;       // one-hot region select
  logic                   hk_sel;
  logic                   dsp_sel;
  logic                   loop_q;
  logic [7:0]             led_q;
  dsp_cfg_t               cfg_q;

  assign region_cs = NUM_REGIONS'(1) << req_i.region;
  assign hk_sel    = region_cs[REGION_HK];
  assign dsp_sel   = region_cs[REGION_DSP];

  ////////////////////////////////////////////////////////////////////////////
  // register writes, all fields live in byte 0
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q        <= 1'b0;
      led_q         <= 8'h00;
      cfg_q.route_a <= ROUTE_PASS;
      cfg_q.route_b <= ROUTE_PASS;
    end
    else if (req_i.wr && req_i.wstrb[0])
    begin
      if (hk_sel && (req_i.offset == HK_LOOP_OFS))
        loop_q <= req_i.wdata[0];
      if (hk_sel && (req_i.offset == HK_LED_OFS))
        led_q <= req_i.wdata[7:0];
      if (dsp_sel && (req_i.offset == DSP_ROUTE_A_OFS))
        cfg_q.route_a <= route_op_e'(req_i.wdata[1:0]);
      if (dsp_sel && (req_i.offset == DSP_ROUTE_B_OFS))
        cfg_q.route_b <= route_op_e'(req_i.wdata[1:0]);
    end
  end

  // read mux, id ignores writes
  always_comb
  begin
    rsp_o = '0;
    if (hk_sel)
    begin
      case (req_i.offset)
        HK_ID_OFS:   rsp_o.rdata = HK_ID_VALUE;
        HK_LOOP_OFS: rsp_o.rdata = {31'd0, loop_q};
        HK_LED_OFS:  rsp_o.rdata = {24'd0, led_q};
        default:     rsp_o.err   = 1'b1;      // hole in hk map
      endcase
    end
    else if (dsp_sel)
    begin
      case (req_i.offset)
        DSP_ROUTE_A_OFS: rsp_o.rdata = {30'd0, cfg_q.route_a};
        DSP_ROUTE_B_OFS: rsp_o.rdata = {30'd0, cfg_q.route_b};
        default:         rsp_o.err   = 1'b1;
      endcase
    end
  end

  assign dsp_cfg_o      = cfg_q;
  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

  // bus slave issues one access per cycle
  a_one_access: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(req_i.wr && req_i.rd));

endmodule

// File: logic/dac_frontend.sv
// stage 3, two's complement back to the dac's negative-slope code
// also holds the dac reset one cycle past the system reset

`timescale 1ns/1ns

module dac_frontend #(
  parameter int DAT_W = rp_pkg::SAMPLE_W
) (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  logic signed [DAT_W-1:0] smp_a_i,
  input  logic signed [DAT_W-1:0] smp_b_i,
  output logic [DAT_W-1:0]        dac_dat_a_o,
  output logic [DAT_W-1:0]        dac_dat_b_o,
  output logic                    dac_rst_o      // active high
);

  // dac code of a zero sample
  localparam logic [DAT_W-1:0] DAC_ZERO = {1'b0, {(DAT_W-1){1'b1}}};

  logic dac_rst_q;

  // output register, msb kept and the rest inverted
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= DAC_ZERO;
      dac_dat_b_o <= DAC_ZERO;
    end
    else
    begin
      dac_dat_a_o <= {smp_a_i[DAT_W-1], ~smp_a_i[DAT_W-2:0]};
      dac_dat_b_o <= {smp_b_i[DAT_W-1], ~smp_b_i[DAT_W-2:0]};
    end
  end

  // set by reset, clears on the first edge after release
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      dac_rst_q <= 1'b1;
    else
      dac_rst_q <= 1'b0;
  end

  assign dac_rst_o = dac_rst_q;

endmodule

// File: logic/rp_pkg.sv
// shared widths, address map, register offsets and bus/config types
// imported by every module of the analog path and bus decode

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;           // raw adc pins, low 2 bits reserved
  localparam int SAMPLE_W  = 14;           // default sample width

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  localparam int REGION_W    = 3;          // region field width
  localparam int REGION_LSB  = 20;         // region sits at addr[22:20]
  localparam int NUM_REGIONS = 8;

  localparam logic [REGION_W-1:0] REGION_HK  = 3'd0;  // housekeeping
  localparam logic [REGION_W-1:0] REGION_DSP = 3'd3;  // dsp routing

  // byte offsets inside a region
  localparam logic [REGION_LSB-1:0] HK_ID_OFS       = 20'h0;
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS     = 20'h4;
  localparam logic [REGION_LSB-1:0] HK_LED_OFS      = 20'h8;
  localparam logic [REGION_LSB-1:0] DSP_ROUTE_A_OFS = 20'h0;
  localparam logic [REGION_LSB-1:0] DSP_ROUTE_B_OFS = 20'h4;

  localparam logic [31:0] HK_ID_VALUE = 32'h5250_0014;  // read-only id

  // axi response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // per-channel routing opcode
  typedef enum logic [1:0] {
    ROUTE_PASS  = 2'd0,                    // own channel
    ROUTE_CROSS = 2'd1,                    // other channel
    ROUTE_NEG   = 2'd2,                    // own channel, saturating negate
    ROUTE_ZERO  = 2'd3
  } route_op_e;

  // one register access
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [REGION_W-1:0]   region;
    logic [REGION_LSB-1:0] offset;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;                      // unmapped offset in a live region
  } reg_rsp_t;

  typedef struct packed {
    route_op_e route_a;
    route_op_e route_b;
  } dsp_cfg_t;

endpackage

// File: logic/rp_top.sv
// board top level, axi4-lite register bus and the three-stage adc to dac path
// everything runs on adc_clk, sample width set here and passed down

`timescale 1ns/1ns

module rp_top #(
  parameter int DAT_W = rp_pkg::SAMPLE_W
) (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  // axi4-lite slave port
  input  logic [31:0]                  s_awaddr_i,
  input  logic                         s_awvalid_i,
  output logic                         s_awready_o,
  input  logic [31:0]                  s_wdata_i,
  input  logic [3:0]                   s_wstrb_i,
  input  logic                         s_wvalid_i,
  output logic                         s_wready_o,
  output logic [1:0]                   s_bresp_o,
  output logic                         s_bvalid_o,
  input  logic                         s_bready_i,
  input  logic [31:0]                  s_araddr_i,
  input  logic                         s_arvalid_i,
  output logic                         s_arready_o,
  output logic [31:0]                  s_rdata_o,
  output logic [1:0]                   s_rresp_o,
  output logic                         s_rvalid_o,
  input  logic                         s_rready_i,
  // converters
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_a_i,   // ch a, low 2 bits reserved
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_b_i,
  output logic [DAT_W-1:0]             dac_dat_a_o,
  output logic [DAT_W-1:0]             dac_dat_b_o,
  output logic                         dac_rst_o,
  output logic [7:0]                   led_o
);

  import rp_pkg::*;

  reg_req_t                reg_req;
  reg_rsp_t                reg_rsp;
  dsp_cfg_t                dsp_cfg;
  logic                    digital_loop;
  logic signed [DAT_W-1:0] adc_a;          // stage 1 out
  logic signed [DAT_W-1:0] adc_b;
  logic signed [DAT_W-1:0] dsp_a;          // stage 2 out, also loop source
  logic signed [DAT_W-1:0] dsp_b;

  ////////////////////////////////////////////////////////////////////////////
  // system bus and registers
  ////////////////////////////////////////////////////////////////////////////

  axil_bus_slave bus_i (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .req_o       (reg_req),
    .rsp_i       (reg_rsp)
  );

  ctrl_regs regs_i (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .req_i          (reg_req),
    .rsp_o          (reg_rsp),
    .dsp_cfg_o      (dsp_cfg),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // sample path, one register per stage
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend #(.DAT_W(DAT_W)) adc_i (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_raw_a_i    (adc_dat_a_i),
    .adc_raw_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dsp_a),
    .loop_b_i       (dsp_b),
    .smp_a_o        (adc_a),
    .smp_b_o        (adc_b)
  );

  signal_router #(.DAT_W(DAT_W)) router_i (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .cfg_i    (dsp_cfg),
    .smp_a_i  (adc_a),
    .smp_b_i  (adc_b),
    .out_a_o  (dsp_a),
    .out_b_o  (dsp_b)
  );

  dac_frontend #(.DAT_W(DAT_W)) dac_i (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .smp_a_i     (dsp_a),
    .smp_b_i     (dsp_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o)
  );

endmodule

// File: logic/signal_router.sv
// stage 2, per-channel route select (pass, cross, negate, zero), registered
// negate saturates so the most negative input gives the most positive output

`timescale 1ns/1ns

module signal_router #(
  parameter int DAT_W = rp_pkg::SAMPLE_W
) (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  rp_pkg::dsp_cfg_t        cfg_i,
  input  logic signed [DAT_W-1:0] smp_a_i,
  input  logic signed [DAT_W-1:0] smp_b_i,
  output logic signed [DAT_W-1:0] out_a_o,
  output logic signed [DAT_W-1:0] out_b_o
);

  import rp_pkg::*;

  localparam logic signed [DAT_W-1:0] SMP_MIN = {1'b1, {(DAT_W-1){1'b0}}};
  localparam logic signed [DAT_W-1:0] SMP_MAX = {1'b0, {(DAT_W-1){1'b1}}};

  logic signed [DAT_W-1:0] route_a;
  logic signed [DAT_W-1:0] route_b;

  // one channel's route, own and other from the channel's point of view
  function automatic logic signed [DAT_W-1:0] route_smp(
    input route_op_e               op,
    input logic signed [DAT_W-1:0] own,
    input logic signed [DAT_W-1:0] other
  );
    logic signed [DAT_W-1:0] res;
    case (op)
      ROUTE_PASS:  res = own;
      ROUTE_CROSS: res = other;
      ROUTE_NEG:   res = (own == SMP_MIN) ? SMP_MAX : -own;  // clip -min
      default:     res = '0;
    endcase
    return res;
  endfunction

  assign route_a = route_smp(cfg_i.route_a, smp_a_i, smp_b_i);
  assign route_b = route_smp(cfg_i.route_b, smp_b_i, smp_a_i);

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      out_a_o <= '0;
      out_b_o <= '0;
    end
    else
    begin
      out_a_o <= route_a;
      out_b_o <= route_b;
    end
  end

  // negate never lets -min through to the dac stage
  a_neg_sat_a: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    cfg_i.route_a == ROUTE_NEG |=> out_a_o != SMP_MIN);
  a_neg_sat_b: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    cfg_i.route_b == ROUTE_NEG |=> out_b_o != SMP_MIN);

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and judges the result from the log

rm -f sim.log
verilator --binary --assert --timescale 1ns/1ns --top-module tb_rp_top -f filelist.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_rp_top | tee sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation failed"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "simulation ended without a pass line"; exit 1; }
echo "simulation passed"
